//--- sd_card_model.sv
`timescale 1ns/10ps
`default_nettype none

module sd_card_model (
    input  wire  sd_clk,
    input  wire  sd_cs,
    input  wire  sd_mosi,
    output logic sd_miso,
    output int   pwr_clk_cnt     // rising sd_clk with cs high before cmd0
);

    sd_pkg::sd_cmd_t  rx_cmd;
    int               rx_bits;
    int               acmd41_cnt;
    logic             got_cmd0;
    sd_pkg::sd_byte_t tx_q[$];   // bytes waiting to go out on miso
    int               tx_bit;

    initial begin
        sd_miso     = 1'b1;
        pwr_clk_cnt = 0;
        rx_cmd      = '1;
        rx_bits     = 0;
        acmd41_cnt  = 0;
        got_cmd0    = 1'b0;
        tx_bit      = 0;
    end

    // ******************************************************************
    // command decode
    // ******************************************************************
    task automatic answer(input sd_pkg::sd_cmd_t cmd);
        sd_pkg::sec_addr_t arg;
        int                i;
        arg = cmd[39:8];
        tx_q.push_back(8'hFF);   // one byte of ncr
        case (cmd[47:40])
            sd_pkg::CMD0: begin
                got_cmd0 = 1'b1;
                tx_q.push_back(sd_pkg::R1_IDLE);
            end
            sd_pkg::CMD8: begin
                tx_q.push_back(sd_pkg::R1_IDLE);
                tx_q.push_back(8'h00);
                tx_q.push_back(8'h00);
                tx_q.push_back({4'h0, arg[11:8]});   // voltage echo
                tx_q.push_back(arg[7:0]);            // check pattern echo
            end
            sd_pkg::CMD55: tx_q.push_back(sd_pkg::R1_IDLE);
            sd_pkg::ACMD41: begin
                acmd41_cnt = acmd41_cnt + 1;
                if (acmd41_cnt <= 3)
                    tx_q.push_back(sd_pkg::R1_IDLE);    // still powering up
                else
                    tx_q.push_back(sd_pkg::R1_READY);
            end
            sd_pkg::CMD17: begin
                tx_q.push_back(sd_pkg::R1_READY);
                tx_q.push_back(8'hFF);
                tx_q.push_back(8'hFF);
                tx_q.push_back(sd_pkg::TOKEN_START);
                for (i = 0; i < 2 * sd_pkg::SECTOR_WORDS; i++)
                    tx_q.push_back(8'(arg + i));
                tx_q.push_back(8'h5A);   // crc, not checked
                tx_q.push_back(8'hC3);
            end
            default: tx_q.push_back(8'h04);   // illegal command
        endcase
    endtask

    always @(posedge sd_clk) begin
        if (sd_cs) begin
            rx_bits = 0;
            if (!got_cmd0)
                pwr_clk_cnt = pwr_clk_cnt + 1;
        end else if (rx_bits > 0 || !sd_mosi) begin   // frame opens with the 0 start bit
            rx_cmd  = {rx_cmd[46:0], sd_mosi};
            rx_bits = rx_bits + 1;
            if (rx_bits == 48) begin
                rx_bits = 0;
                answer(rx_cmd);
            end
        end
    end

    // msb first, one bit per falling edge
    always @(negedge sd_clk) begin
        if (tx_q.size() == 0) begin
            sd_miso <= 1'b1;
        end else begin
            sd_miso <= tx_q[0][7 - tx_bit];
            if (tx_bit == 7) begin
                tx_bit = 0;
                void'(tx_q.pop_front());
            end else begin
                tx_bit = tx_bit + 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- sd_ctrl_top.sv
`timescale 1ns/10ps
`default_nettype none

module sd_ctrl_top #(
    parameter int INIT_CLK_DIV = 4,     // half period of init clock in clk_ref cycles
    parameter int RESP_TIMEOUT = 64     // bytes to wait for response or token
) (
    input  wire                clk_ref,
    input  wire                arst_n,
    // card pins
    input  wire                sd_miso,
    output logic               sd_clk,
    output logic               sd_cs,
    output logic               sd_mosi,
    // user read side
    input  wire                rd_start_en,
    input  wire sd_pkg::sec_addr_t rd_sec_addr,
    output logic               rd_busy,
    output logic               rd_val_en,
    output sd_pkg::rd_word_t   rd_val_data,
    output logic               sd_init_done
);

    logic init_sd_clk;
    logic init_sd_cs;
    logic init_sd_mosi;
    logic rd_sd_cs;
    logic rd_sd_mosi;
    logic rd_start_gated;   // start only honoured once the card is ready

    // ******************************************************************
    // pin selection
    // ******************************************************************
    assign sd_clk = sd_init_done ? ~clk_ref : init_sd_clk;

    always_comb begin
        if (!sd_init_done) begin
            sd_cs   = init_sd_cs;
            sd_mosi = init_sd_mosi;
        end else if (rd_busy) begin
            sd_cs   = rd_sd_cs;
            sd_mosi = rd_sd_mosi;
        end else begin
            sd_cs   = 1'b1;   // card deselected between reads
            sd_mosi = 1'b1;
        end
    end

    assign rd_start_gated = rd_start_en & sd_init_done;

    sd_init #(
        .INIT_CLK_DIV (INIT_CLK_DIV),
        .RESP_TIMEOUT (RESP_TIMEOUT)
    ) u_sd_init (
        .clk_ref      (clk_ref),
        .arst_n       (arst_n),
        .sd_miso      (sd_miso),
        .sd_clk       (init_sd_clk),
        .sd_cs        (init_sd_cs),
        .sd_mosi      (init_sd_mosi),
        .sd_init_done (sd_init_done)
    );

    sd_read #(
        .RESP_TIMEOUT (RESP_TIMEOUT)
    ) u_sd_read (
        .clk_ref      (clk_ref),
        .arst_n       (arst_n),
        .sd_miso      (sd_miso),
        .sd_cs        (rd_sd_cs),
        .sd_mosi      (rd_sd_mosi),
        .rd_start_en  (rd_start_gated),
        .rd_sec_addr  (rd_sec_addr),
        .rd_busy      (rd_busy),
        .rd_val_en    (rd_val_en),
        .rd_val_data  (rd_val_data)
    );

endmodule

`default_nettype wire

//--- sd_init.sv
`timescale 1ns/10ps
`default_nettype none

module sd_init #(
    parameter int INIT_CLK_DIV = 4,
    parameter int RESP_TIMEOUT = 64
) (
    input  wire  clk_ref,
    input  wire  arst_n,
    input  wire  sd_miso,
    output logic sd_clk,
    output logic sd_cs,
    output logic sd_mosi,
    output logic sd_init_done
);

    localparam int DIV_W    = $clog2(INIT_CLK_DIV + 1);
    localparam int POLL_W   = $clog2(RESP_TIMEOUT + 1);
    localparam int PWR_CLKS = 80;   // spec asks for at least 74

    typedef enum logic [3:0] {
        ST_POWERUP,
        ST_CMD0,
        ST_CMD8,
        ST_CMD55,
        ST_ACMD41,
        ST_SEND,
        ST_RESP,
        ST_R7,
        ST_GAP,
        ST_DONE
    } init_st_t;

    init_st_t          state;
    init_st_t          cmd_st;     // command in flight
    init_st_t          nxt_st;     // where to go after the gap
    init_st_t          resp_nxt;
    logic [DIV_W-1:0]  div_cnt;
    logic              div_end;
    logic              rise_stb;
    logic              fall_stb;
    sd_pkg::sd_cmd_t   cmd_frame;
    sd_pkg::sd_cmd_t   cmd_sr;
    sd_pkg::sd_byte_t  rx_sr;
    sd_pkg::sd_byte_t  rx_byte;
    logic [6:0]        bit_cnt;
    logic [2:0]        rx_cnt;
    logic [POLL_W-1:0] poll_cnt;

    // ******************************************************************
    // slow clock and phase strobes
    // ******************************************************************
    assign div_end  = (div_cnt == DIV_W'(INIT_CLK_DIV - 1));
    assign rise_stb = div_end & ~sd_clk;   // sample miso here
    assign fall_stb = div_end & sd_clk;    // update mosi here

    always_ff @(posedge clk_ref or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;
            sd_clk  <= 1'b0;
        end else if (div_end) begin
            div_cnt <= '0;
            sd_clk  <= ~sd_clk;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_comb begin
        case (state)
            ST_CMD0:   cmd_frame = {sd_pkg::CMD0, 32'h0, sd_pkg::CRC_CMD0};
            ST_CMD8:   cmd_frame = {sd_pkg::CMD8, sd_pkg::CMD8_ARG, sd_pkg::CRC_CMD8};
            ST_CMD55:  cmd_frame = {sd_pkg::CMD55, 32'h0, sd_pkg::CRC_DUMMY};
            ST_ACMD41: cmd_frame = {sd_pkg::ACMD41, sd_pkg::ACMD41_ARG, sd_pkg::CRC_DUMMY};
            default:   cmd_frame = '1;
        endcase
    end

    assign rx_byte = {rx_sr[6:0], sd_miso};

    // next step per response, anything unexpected goes back to cmd0
    always_comb begin
        resp_nxt = ST_CMD0;
        case (cmd_st)
            ST_CMD0:  if (rx_byte == sd_pkg::R1_IDLE) resp_nxt = ST_CMD8;
            ST_CMD8:  if (rx_byte == sd_pkg::R1_IDLE) resp_nxt = ST_CMD55;
            ST_CMD55: if (rx_byte == sd_pkg::R1_IDLE) resp_nxt = ST_ACMD41;
            ST_ACMD41: begin
                if (rx_byte == sd_pkg::R1_IDLE)
                    resp_nxt = ST_CMD55;          // card still busy
                else if (rx_byte == sd_pkg::R1_READY)
                    resp_nxt = ST_DONE;
            end
            default: ;
        endcase
    end

    // command shifter and response byte
    always_ff @(posedge clk_ref) begin
        if (fall_stb) begin
            if (state inside {ST_CMD0, ST_CMD8, ST_CMD55, ST_ACMD41})
                cmd_sr <= {cmd_frame[46:0], 1'b1};
            else if (state == ST_SEND)
                cmd_sr <= {cmd_sr[46:0], 1'b1};
        end
        if (rise_stb && state == ST_RESP)
            rx_sr <= rx_byte;
    end

    // ******************************************************************
    // init sequence
    // ******************************************************************
    always_ff @(posedge clk_ref or negedge arst_n) begin
        if (!arst_n) begin
            state        <= ST_POWERUP;
            cmd_st       <= ST_CMD0;
            nxt_st       <= ST_CMD0;
            bit_cnt      <= '0;
            rx_cnt       <= '0;
            poll_cnt     <= '0;
            sd_cs        <= 1'b1;
            sd_mosi      <= 1'b1;
            sd_init_done <= 1'b0;
        end else begin
            case (state)
                ST_POWERUP: if (fall_stb) begin   // clocks with cs high
                    if (bit_cnt == 7'(PWR_CLKS - 1)) begin
                        bit_cnt <= '0;
                        state   <= ST_CMD0;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                ST_CMD0, ST_CMD8, ST_CMD55, ST_ACMD41: if (fall_stb) begin
                    sd_cs   <= 1'b0;
                    sd_mosi <= cmd_frame[47];
                    bit_cnt <= 7'd47;
                    cmd_st  <= state;
                    state   <= ST_SEND;
                end
                ST_SEND: if (fall_stb) begin
                    if (bit_cnt == '0) begin
                        sd_mosi  <= 1'b1;
                        rx_cnt   <= '0;
                        poll_cnt <= '0;
                        state    <= ST_RESP;
                    end else begin
                        sd_mosi <= cmd_sr[47];
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
                ST_RESP: if (rise_stb) begin
                    rx_cnt <= rx_cnt + 1'b1;
                    if (rx_cnt == 3'd7) begin
                        if (rx_byte == 8'hFF && poll_cnt != POLL_W'(RESP_TIMEOUT - 1)) begin
                            poll_cnt <= poll_cnt + 1'b1;
                        end else begin
                            nxt_st <= resp_nxt;
                            if (cmd_st == ST_CMD8 && resp_nxt == ST_CMD55) begin
                                bit_cnt <= 7'd31;     // r7 tail
                                state   <= ST_R7;
                            end else begin
                                bit_cnt <= 7'd8;
                                state   <= ST_GAP;
                            end
                        end
                    end
                end
                ST_R7: if (rise_stb) begin
                    if (bit_cnt == '0) begin
                        bit_cnt <= 7'd8;
                        state   <= ST_GAP;
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
                ST_GAP: if (fall_stb) begin   // deselect and idle clocks
                    sd_cs <= 1'b1;
                    if (bit_cnt == '0)
                        state <= nxt_st;
                    else
                        bit_cnt <= bit_cnt - 1'b1;
                end
                ST_DONE: sd_init_done <= 1'b1;
                default: state <= ST_POWERUP;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- sd_pkg.sv
`default_nettype none

package sd_pkg;

    // ******************************************************************
    // widths with a meaning
    // ******************************************************************
    typedef logic [31:0] sec_addr_t;    // block address, SDHC style
    typedef logic [15:0] rd_word_t;
    typedef logic [7:0]  sd_byte_t;
    typedef logic [47:0] sd_cmd_t;      // index + argument + crc byte

    // command index bytes with start and transmission bits set
    localparam sd_byte_t CMD0   = 8'h40;
    localparam sd_byte_t CMD8   = 8'h48;
    localparam sd_byte_t CMD17  = 8'h51;
    localparam sd_byte_t CMD55  = 8'h77;
    localparam sd_byte_t ACMD41 = 8'h69;

    // crc7 plus end bit
    localparam sd_byte_t CRC_CMD0  = 8'h95;
    localparam sd_byte_t CRC_CMD8  = 8'h87;
    localparam sd_byte_t CRC_DUMMY = 8'hFF;   // crc not checked in spi mode

    localparam sec_addr_t CMD8_ARG   = 32'h0000_01AA;   // 2.7-3.6 V, check pattern
    localparam sec_addr_t ACMD41_ARG = 32'h4000_0000;   // hcs set

    localparam sd_byte_t R1_IDLE     = 8'h01;
    localparam sd_byte_t R1_READY    = 8'h00;
    localparam sd_byte_t TOKEN_START = 8'hFE;

    localparam int SECTOR_WORDS = 256;

endpackage

`default_nettype wire

//--- sd_read.sv
`timescale 1ns/10ps
`default_nettype none

module sd_read #(
    parameter int RESP_TIMEOUT = 64
) (
    input  wire                    clk_ref,
    input  wire                    arst_n,
    input  wire                    sd_miso,
    output logic                   sd_cs,
    output logic                   sd_mosi,
    input  wire                    rd_start_en,
    input  wire sd_pkg::sec_addr_t rd_sec_addr,
    output logic                   rd_busy,
    output logic                   rd_val_en,
    output sd_pkg::rd_word_t       rd_val_data
);

    localparam int POLL_W     = $clog2(RESP_TIMEOUT + 1);
    localparam int DATA_BYTES = 2 * sd_pkg::SECTOR_WORDS;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SEND,
        ST_R1,
        ST_TOKEN,
        ST_DATA,
        ST_CRC,
        ST_TRAIL
    } rd_st_t;

    rd_st_t            state;
    sd_pkg::sd_cmd_t   cmd_frame;
    sd_pkg::sd_cmd_t   cmd_sr;
    sd_pkg::sd_byte_t  miso_sr;
    logic [5:0]        cnt;        // command bits and trailing clocks
    logic [3:0]        bit_cnt;
    logic              byte_rdy;
    logic [8:0]        byte_cnt;
    logic [POLL_W-1:0] poll_cnt;
    logic              poll_end;

    assign cmd_frame = {sd_pkg::CMD17, rd_sec_addr, sd_pkg::CRC_DUMMY};
    assign byte_rdy  = (bit_cnt == 4'd8);   // eight fresh bits in miso_sr
    assign poll_end  = (poll_cnt == POLL_W'(RESP_TIMEOUT - 1));

    // falling clk_ref is the rising sd_clk edge
    always_ff @(negedge clk_ref) begin
        miso_sr <= {miso_sr[6:0], sd_miso};
    end

    always_ff @(posedge clk_ref) begin
        if (state == ST_IDLE)
            cmd_sr <= {cmd_frame[46:0], 1'b1};   // first bit goes out directly
        else if (state == ST_SEND)
            cmd_sr <= {cmd_sr[46:0], 1'b1};
        if (state == ST_DATA && byte_rdy)
            rd_val_data <= {rd_val_data[7:0], miso_sr};   // first byte ends up high
    end

    // ******************************************************************
    // cmd17 transaction
    // ******************************************************************
    always_ff @(posedge clk_ref or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_IDLE;
            sd_cs     <= 1'b1;
            sd_mosi   <= 1'b1;
            rd_busy   <= 1'b0;
            rd_val_en <= 1'b0;
            cnt       <= '0;
            bit_cnt   <= '0;
            byte_cnt  <= '0;
            poll_cnt  <= '0;
        end else begin
            rd_val_en <= 1'b0;
            // byte framing runs freely once the command is out
            if (state != ST_IDLE && state != ST_SEND)
                bit_cnt <= byte_rdy ? 4'd1 : bit_cnt + 1'b1;

            case (state)
                ST_IDLE: if (rd_start_en) begin
                    rd_busy <= 1'b1;
                    sd_cs   <= 1'b0;
                    sd_mosi <= cmd_frame[47];
                    cnt     <= '0;
                    state   <= ST_SEND;
                end
                ST_SEND: begin
                    sd_mosi <= cmd_sr[47];
                    cnt     <= cnt + 1'b1;
                    if (cnt == 6'd46) begin    // last bit on the line
                        bit_cnt  <= '0;
                        poll_cnt <= '0;
                        state    <= ST_R1;
                    end
                end
                ST_R1: begin
                    sd_mosi <= 1'b1;
                    if (byte_rdy) begin
                        if (miso_sr == sd_pkg::R1_READY) begin
                            poll_cnt <= '0;
                            state    <= ST_TOKEN;
                        end else if (miso_sr != 8'hFF || poll_end) begin
                            cnt   <= '0;           // error or timeout
                            state <= ST_TRAIL;
                        end else begin
                            poll_cnt <= poll_cnt + 1'b1;
                        end
                    end
                end
                ST_TOKEN: if (byte_rdy) begin
                    if (miso_sr == sd_pkg::TOKEN_START) begin
                        byte_cnt <= '0;
                        state    <= ST_DATA;
                    end else if (poll_end) begin
                        cnt   <= '0;
                        state <= ST_TRAIL;
                    end else begin
                        poll_cnt <= poll_cnt + 1'b1;
                    end
                end
                ST_DATA: if (byte_rdy) begin
                    rd_val_en <= byte_cnt[0];   // word complete on odd byte
                    byte_cnt  <= byte_cnt + 1'b1;
                    if (byte_cnt == 9'(DATA_BYTES - 1)) begin
                        byte_cnt <= '0;
                        state    <= ST_CRC;
                    end
                end
                ST_CRC: if (byte_rdy) begin     // two crc bytes dropped
                    byte_cnt <= byte_cnt + 1'b1;
                    if (byte_cnt[0]) begin
                        cnt   <= '0;
                        state <= ST_TRAIL;
                    end
                end
                ST_TRAIL: begin
                    sd_mosi <= 1'b1;
                    cnt     <= cnt + 1'b1;
                    if (cnt == 6'd7) begin     // 8 clocks then release
                        sd_cs   <= 1'b1;
                        rd_busy <= 1'b0;
                        state   <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- sd_tests.txt
# sector address, expected first word, expected sum of all 256 words mod 65536
# all values in hex
00000000 0001 8000
00000001 0102 7f00
00000010 1011 8000
000000ff ff00 7f00
00001234 3435 8000
0000abcd cdce 7f00
12345678 7879 8000
deadbeef eff0 7f00
fffffffe feff 8000
80000003 0304 7f00

//--- sim.f
sd_pkg.sv
sd_init.sv
sd_read.sv
sd_ctrl_top.sv
sd_card_model.sv
tb_sd_ctrl.sv

//--- tb_sd_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module tb_sd_ctrl;

    localparam int INIT_TIMEOUT = 50000;   // clk_ref cycles
    localparam int READ_TIMEOUT = 10000;

    logic              clk_ref;
    logic              arst_n;
    logic              sd_clk;
    logic              sd_cs;
    logic              sd_mosi;
    logic              sd_miso;
    logic              rd_start_en;
    sd_pkg::sec_addr_t rd_sec_addr;
    logic              rd_busy;
    logic              rd_val_en;
    sd_pkg::rd_word_t  rd_val_data;
    logic              sd_init_done;
    int                pwr_clk_cnt;
    integer            seed;

    sd_ctrl_top #(
        .INIT_CLK_DIV (4)
    ) u_dut (
        .clk_ref      (clk_ref),
        .arst_n       (arst_n),
        .sd_miso      (sd_miso),
        .sd_clk       (sd_clk),
        .sd_cs        (sd_cs),
        .sd_mosi      (sd_mosi),
        .rd_start_en  (rd_start_en),
        .rd_sec_addr  (rd_sec_addr),
        .rd_busy      (rd_busy),
        .rd_val_en    (rd_val_en),
        .rd_val_data  (rd_val_data),
        .sd_init_done (sd_init_done)
    );

    sd_card_model u_card (
        .sd_clk      (sd_clk),
        .sd_cs       (sd_cs),
        .sd_mosi     (sd_mosi),
        .sd_miso     (sd_miso),
        .pwr_clk_cnt (pwr_clk_cnt)
    );

    always #20 clk_ref = ~clk_ref;

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "stopped at first error");
    endtask

    // byte i of sector a is the low byte of a + i
    function automatic sd_pkg::rd_word_t word_at(input sd_pkg::sec_addr_t addr, input int k);
        sd_pkg::sd_byte_t hi;
        sd_pkg::sd_byte_t lo;
        hi = 8'(addr + 2 * k);
        lo = 8'(addr + 2 * k + 1);
        return {hi, lo};
    endfunction

    function automatic sd_pkg::rd_word_t sector_sum(input sd_pkg::sec_addr_t addr);
        sd_pkg::rd_word_t sum;
        sum = '0;
        for (int k = 0; k < sd_pkg::SECTOR_WORDS; k++)
            sum = sum + word_at(addr, k);
        return sum;
    endfunction

    task automatic check_reset_outputs();
        assert (sd_cs == 1'b1) else fail_stop($sformatf("[FAIL] sd_cs exp 1 got %h", sd_cs));
        assert (rd_busy == 1'b0) else fail_stop($sformatf("[FAIL] rd_busy exp 0 got %h", rd_busy));
        assert (rd_val_en == 1'b0)
            else fail_stop($sformatf("[FAIL] rd_val_en exp 0 got %h", rd_val_en));
        assert (sd_init_done == 1'b0)
            else fail_stop($sformatf("[FAIL] sd_init_done exp 0 got %h", sd_init_done));
    endtask

    task automatic wait_init_done();
        int cyc;
        cyc = 0;
        while (!sd_init_done) begin
            assert (rd_busy == 1'b0)
                else fail_stop($sformatf("[FAIL] rd_busy before init exp 0 got %h", rd_busy));
            cyc++;
            assert (cyc < INIT_TIMEOUT) else fail_stop("sd_init_done did not rise in time");
            @(negedge clk_ref);
        end
    endtask

    task automatic idle_gap(input int cycles);
        repeat (cycles) begin
            @(negedge clk_ref);
            assert (sd_cs == 1'b1)
                else fail_stop($sformatf("[FAIL] sd_cs between reads exp 1 got %h", sd_cs));
            assert (sd_mosi == 1'b1)
                else fail_stop($sformatf("[FAIL] sd_mosi between reads exp 1 got %h", sd_mosi));
            // sd_clk follows inverted clk_ref once init is done
            #10;
            assert (sd_clk == 1'b1)
                else fail_stop($sformatf("[FAIL] sd_clk in low clk_ref phase exp 1 got %h", sd_clk));
            #20;
            assert (sd_clk == 1'b0)
                else fail_stop($sformatf("[FAIL] sd_clk in high clk_ref phase exp 0 got %h", sd_clk));
        end
    endtask

    // ******************************************************************
    // one sector read, optional extra start while busy
    // ******************************************************************
    task automatic run_read(input sd_pkg::sec_addr_t addr, input sd_pkg::rd_word_t exp_first,
                            input sd_pkg::rd_word_t exp_sum, input bit dbl_start);
        int               cyc;
        int               words;
        sd_pkg::rd_word_t sum;
        sd_pkg::rd_word_t first;
        sd_pkg::rd_word_t exp_word;
        cyc   = 0;
        words = 0;
        sum   = '0;
        first = '0;
        @(negedge clk_ref);
        assert (rd_busy == 1'b0) else fail_stop("read started while the card was still busy");
        rd_sec_addr = addr;
        rd_start_en = 1'b1;
        @(negedge clk_ref);
        rd_start_en = 1'b0;
        assert (rd_busy == 1'b1)
            else fail_stop($sformatf("[FAIL] rd_busy one cycle after start exp 1 got %h", rd_busy));
        while (rd_busy) begin
            if (rd_val_en) begin
                assert (words < sd_pkg::SECTOR_WORDS)
                    else fail_stop("more than 256 words in a read");
                exp_word = word_at(addr, words);
                assert (rd_val_data == exp_word) else fail_stop($sformatf(
                    "[FAIL] rd_val_data word %0d exp %h got %h", words, exp_word, rd_val_data));
                if (words == 0)
                    first = rd_val_data;
                sum   = sum + rd_val_data;
                words = words + 1;
            end
            rd_start_en = dbl_start && (cyc == 200);   // must be ignored
            if (rd_start_en)
                rd_sec_addr = addr + 32'h55;
            cyc++;
            assert (cyc < READ_TIMEOUT) else fail_stop("rd_busy did not fall in time");
            @(negedge clk_ref);
        end
        rd_start_en = 1'b0;
        assert (rd_val_en == 1'b0)
            else fail_stop($sformatf("[FAIL] rd_val_en after read exp 0 got %h", rd_val_en));
        assert (words == sd_pkg::SECTOR_WORDS)
            else fail_stop($sformatf("[FAIL] word count exp %h got %h", 256, words));
        assert (first == exp_first)
            else fail_stop($sformatf("[FAIL] first rd_val_data exp %h got %h", exp_first, first));
        assert (sum == exp_sum)
            else fail_stop($sformatf("[FAIL] rd_val_data sum exp %h got %h", exp_sum, sum));
    endtask

    initial begin
        int                fd;
        int                n;
        int                ntests;
        string             line;
        sd_pkg::sec_addr_t addr;
        sd_pkg::rd_word_t  exp_first;
        sd_pkg::rd_word_t  exp_sum;
        clk_ref     = 1'b0;
        arst_n      = 1'b0;
        rd_start_en = 1'b0;
        rd_sec_addr = '0;
        seed        = 32'h6f88;
        ntests      = 0;

        repeat (16) begin
            @(negedge clk_ref);
            check_reset_outputs();
        end
        arst_n = 1'b1;
        repeat (4) begin
            @(negedge clk_ref);
            check_reset_outputs();
        end

        // start while the card is not ready yet
        rd_sec_addr = 32'h0000_0042;
        rd_start_en = 1'b1;
        @(negedge clk_ref);
        rd_start_en = 1'b0;
        wait_init_done();
        assert (pwr_clk_cnt >= 74)
            else fail_stop($sformatf("[FAIL] pwr_clk_cnt exp >= 4a got %h", pwr_clk_cnt));

        // ******************************************************************
        // reads from the test file, then a few random sectors
        // ******************************************************************
        fd = $fopen("sd_tests.txt", "r");
        assert (fd != 0) else fail_stop("could not open sd_tests.txt");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line[0] != "#") begin
                n = $sscanf(line, "%h %h %h", addr, exp_first, exp_sum);
                if (n == 3) begin
                    run_read(addr, exp_first, exp_sum, (ntests % 3) == 1);
                    idle_gap(4 + ($unsigned($random(seed)) % 24));
                    ntests++;
                end
            end
        end
        $fclose(fd);
        assert (ntests > 0) else fail_stop("no tests found in sd_tests.txt");

        repeat (3) begin
            addr = $random(seed);
            run_read(addr, word_at(addr, 0), sector_sum(addr), 1'b0);
            idle_gap(4 + ($unsigned($random(seed)) % 24));
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire
